/* tb.f */
+incdir+src
src/corePkg.sv
src/controlCore.sv
src/aluUnit.sv
src/barrelShift.sv
src/regBank.sv
src/hostPort.sv
src/miniCpu.sv
sim/miniCpu_tb.sv

/* sim/miniCpu_tb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module miniCpu_tb;

        localparam int waitLimit = 100;

        logic clk, rstN;
        logic [`AXI_AW-1:0] awaddr, araddr;
        logic [`AXI_DW-1:0] wdata, rdata;
        logic awvalid, wvalid, bready, arvalid, rready;
        logic awready, wready, bvalid, arready, rvalid;
        logic [1:0] bresp, rresp;

        logic [`DATA_W-1:0] shadow [`REG_N];
        logic modelRunning, timedOut;
        logic [31:0] seed;
        string testName;
        int checks, fails, testFails, tests;
        int aluIds [21] = '{4, 23, 5, 22, 6, 10, 7, 9, 11, 12, 13, 17, 18, 20, 21, 24, 25,
                26, 34, 65, 35};
        int shiftIds [7] = '{1, 2, 3, 14, 15, 16, 19};

        miniCpu uut (.*);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic logic [31:0] nextRand();
                seed = seed * 32'd1664525 + 32'd1013904223;
                return seed;
        endfunction

        task automatic checkValue(input string what, input logic [31:0] exp,
                        input logic [31:0] got);
                checks++;
                assert (got === exp) else begin
                        $display("error %s (%s): expected %h, actual %h", testName, what, exp, got);
                        fails++;
                        testFails++;
                end
        endtask

        task automatic reportTimeout(input string what);
                $display("%s: timed out, %s", testName, what);
                timedOut = 1'b1;
        endtask

        task automatic axiWrite(input logic [`AXI_AW-1:0] addr, input logic [`AXI_DW-1:0] data,
                        input int hold, output logic [1:0] resp);
                int cycles;
                resp = 2'bxx;
                if (timedOut) return;
                @(posedge clk);
                awaddr <= addr;
                wdata <= data;
                awvalid <= 1'b1;
                wvalid <= 1'b1;
                cycles = 0;
                do begin
                        @(posedge clk);
                        cycles++;
                end while (!(awready && wready) && cycles < waitLimit);
                awvalid <= 1'b0;
                wvalid <= 1'b0;
                if (!(awready && wready)) begin
                        reportTimeout("write address and data were never accepted");
                        return;
                end
                cycles = 0;
                do begin
                        @(posedge clk);
                        cycles++;
                end while (!bvalid && cycles < waitLimit);
                if (!bvalid) begin
                        reportTimeout("no write response arrived");
                        return;
                end
                resp = bresp;
                // bready stays low here, the response has to wait
                repeat (hold) begin
                        @(posedge clk);
                        checkValue("bvalid while stalled", 1, bvalid);
                        checkValue("bresp while stalled", resp, bresp);
                end
                bready <= 1'b1;
                @(posedge clk);
                bready <= 1'b0;
        endtask

        task automatic axiRead(input logic [`AXI_AW-1:0] addr, input int hold,
                        output logic [`AXI_DW-1:0] data, output logic [1:0] resp);
                int cycles;
                data = 'x;
                resp = 2'bxx;
                if (timedOut) return;
                @(posedge clk);
                araddr <= addr;
                arvalid <= 1'b1;
                cycles = 0;
                do begin
                        @(posedge clk);
                        cycles++;
                end while (!arready && cycles < waitLimit);
                arvalid <= 1'b0;
                if (!arready) begin
                        reportTimeout("read address was never accepted");
                        return;
                end
                cycles = 0;
                do begin
                        @(posedge clk);
                        cycles++;
                end while (!rvalid && cycles < waitLimit);
                if (!rvalid) begin
                        reportTimeout("no read data arrived");
                        return;
                end
                data = rdata;
                resp = rresp;
                repeat (hold) begin
                        @(posedge clk);
                        checkValue("rvalid while stalled", 1, rvalid);
                        checkValue("rdata while stalled", data, rdata);
                        checkValue("rresp while stalled", resp, rresp);
                end
                rready <= 1'b1;
                @(posedge clk);
                rready <= 1'b0;
        endtask

        // reference model of one instruction, straight from the id table
        task automatic applyModel(input logic [15:0] w);
                logic [6:0] id;
                logic useImm, writes;
                logic [`DATA_W-1:0] a, b, y;
                logic [3:0] amt;
                id = w[15:9];
                case (id)
                        7'd1, 7'd2, 7'd3, 7'd6, 7'd7, 7'd8, 7'd9, 7'd10, 7'd11: useImm = 1'b1;
                        default: useImm = 1'b0;
                endcase
                a = useImm ? shadow[w[8:6]] : shadow[w[5:3]];
                b = useImm ? {{(`DATA_W-6){w[5]}}, w[5:0]} : shadow[w[2:0]];
                amt = b[3:0];
                writes = 1'b1;
                case (id)
                        7'd1, 7'd14: y = a >> amt;
                        7'd2, 7'd15: y = $signed(a) >>> amt;
                        7'd3, 7'd16: y = a << amt;
                        7'd19: y = (a << amt) | (a >> (`DATA_W - amt));
                        7'd4, 7'd23, 7'd6, 7'd10: y = a + b;
                        7'd5, 7'd22, 7'd7, 7'd9, 7'd11: y = a ^ b;
                        7'd8, 7'd35, 7'd36, 7'd37: y = b;
                        7'd12: y = a - b;
                        7'd13: y = a * b;
                        7'd17: y = a & b;
                        7'd18: y = ~(a | b);
                        7'd20: y = a;
                        7'd21: y = ~a;
                        7'd24: y = ~(a & b);
                        7'd25: y = ~(a ^ b);
                        7'd26: y = a | b;
                        7'd34: y = ($signed(a) < $signed(b)) ? 1 : 0;
                        7'd65: y = -b;
                        default: begin
                                y = '0;
                                writes = 1'b0;
                        end
                endcase
                if (id == 7'd75) modelRunning = 1'b0;
                if (id == 7'd100) begin
                        for (int k = 0; k < `REG_N; k++) shadow[k] = '0;
                end
                if (writes) shadow[w[8:6]] = y;
        endtask

        task automatic runInstr(input logic [15:0] w, input int hold);
                logic [1:0] resp, expResp;
                expResp = modelRunning ? `RESP_OKAY : `RESP_SLVERR;
                axiWrite(`ADDR_INSTR, {16'h0, w}, hold, resp);
                checkValue($sformatf("bresp of %h", w), expResp, resp);
                if (modelRunning) applyModel(w);
        endtask

        task automatic readAndCompare(input int k, input int hold);
                logic [`AXI_DW-1:0] data;
                logic [1:0] resp;
                axiRead(`ADDR_REG0 + 4 * k, hold, data, resp);
                checkValue($sformatf("r%0d", k), {16'h0, shadow[k]}, data);
                checkValue($sformatf("rresp of r%0d", k), `RESP_OKAY, resp);
        endtask

        task automatic compareAll();
                for (int k = 0; k < `REG_N; k++) readAndCompare(k, 0);
        endtask

        task automatic endTest();
                tests++;
                $display("test %s finished with %0d failures", testName, testFails);
                testFails = 0;
        endtask

        initial begin
                logic [31:0] r, data;
                logic [1:0] resp;
                logic [15:0] w;
                rstN = 1'b0;
                awaddr = '0;
                araddr = '0;
                wdata = '0;
                {awvalid, wvalid, bready, arvalid, rready} = '0;
                seed = 32'h92ec_c283;
                {checks, fails, testFails, tests} = '0;
                modelRunning = 1'b1;
                timedOut = 1'b0;
                for (int k = 0; k < `REG_N; k++) shadow[k] = '0;
                repeat (3) @(posedge clk);
                rstN <= 1'b1;

                testName = "reset";
                compareAll();
                axiRead(`ADDR_STATUS, 0, data, resp);
                checkValue("status", 32'd1, data);
                runInstr({7'd74, 9'h0}, 0);
                endTest();

                testName = "alu";
                for (int k = 0; k < `REG_N; k++) begin
                        r = nextRand();
                        runInstr({7'd8, k[2:0], r[27:22]}, 0);
                end
                compareAll();
                for (int i = 0; i < 21; i++) begin
                        repeat (2) begin
                                r = nextRand();
                                w = {aluIds[i][6:0], r[31:23]};
                                runInstr(w, 0);
                                readAndCompare(w[8:6], 0);
                        end
                end
                endTest();

                testName = "shift";
                for (int i = 0; i < 7; i++) begin
                        repeat (3) begin
                                r = nextRand();
                                w = {shiftIds[i][6:0], r[31:23]};
                                runInstr(w, 0);
                                readAndCompare(w[8:6], 0);
                        end
                end
                endTest();

                testName = "ignored ids";
                repeat (6) begin
                        r = nextRand();
                        runInstr({7'(38 + r[31:16] % 36), r[24:16]}, 0);
                end
                runInstr({7'd74, 9'h1ff}, 0);
                compareAll();
                runInstr({7'd100, 9'h0}, 0);
                compareAll();
                endTest();

                testName = "backpressure";
                runInstr({7'd8, 3'd5, 6'h2a}, 0);
                runInstr({7'd6, 3'd5, 6'h07}, 4);
                readAndCompare(5, 4);
                endTest();

                testName = "halt";
                runInstr({7'd75, 9'h0}, 0);
                axiRead(`ADDR_STATUS, 0, data, resp);
                checkValue("status after halt", 32'd0, data);
                runInstr({7'd8, 3'd2, 6'h15}, 0);
                compareAll();
                axiRead(8'hc0, 0, data, resp);
                checkValue("unmapped rdata", 32'd0, data);
                checkValue("unmapped rresp", `RESP_SLVERR, resp);
                endTest();

                $display("%0d tests, %0d checks, %0d failures", tests, checks, fails);
                if (fails == 0 && !timedOut) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

endmodule

/* src/miniCpu.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module miniCpu
        import corePkg::*;
(
        input  logic clk,
        input  logic rstN,
        input  logic [`AXI_AW-1:0] awaddr,
        input  logic awvalid,
        output logic awready,
        input  logic [`AXI_DW-1:0] wdata,
        input  logic wvalid,
        output logic wready,
        output logic [1:0] bresp,
        output logic bvalid,
        input  logic bready,
        input  logic [`AXI_AW-1:0] araddr,
        input  logic arvalid,
        output logic arready,
        output logic [`AXI_DW-1:0] rdata,
        output logic [1:0] rresp,
        output logic rvalid,
        input  logic rready
);

        instrWord_u instr;
        ctrlBundle_t ctrl;
        logic execValid;
        logic [$clog2(`REG_N)-1:0] hostAddr, srcAAddr;
        logic [`DATA_W-1:0] hostData, rsData, rtData;
        logic [`DATA_W-1:0] immExt, opB, aluY, shiftY, result;

        hostPort host (
                .clk, .rstN,
                .awaddr, .awvalid, .awready,
                .wdata, .wvalid, .wready,
                .bresp, .bvalid, .bready,
                .araddr, .arvalid, .arready,
                .rdata, .rresp, .rvalid, .rready,
                .execValid, .instr,
                .haltReq(!ctrl.enable),
                .regAddr(hostAddr),
                .regData(hostData)
        );

        controlCore decode (.id(instr.rForm.id), .ctrl);

        // immediate form reads rd as operand A
        assign srcAAddr = ctrl.useImm ? instr.iForm.rd : instr.rForm.rs;
        assign immExt = {{(`DATA_W-6){instr.iForm.imm6[5]}}, instr.iForm.imm6};
        assign opB = ctrl.useImm ? immExt : rtData;

        aluUnit alu (.op(ctrl.aluOp), .a(rsData), .b(opB), .y(aluY));

        barrelShift shifter (.op(ctrl.bsOp), .a(rsData), .b(opB), .y(shiftY));

        assign result = (ctrl.bsOp != SH_NONE) ? shiftY : aluY;

        regBank regs (
                .clk, .rstN,
                .we(execValid && (ctrl.rbMode == 3'd1)),
                .clear(execValid && ctrl.clearRegs),
                .wAddr(instr.rForm.rd),
                .wData(result),
                .rsAddr(srcAAddr),
                .rtAddr(instr.rForm.rt),
                .rsData, .rtData,
                .hostAddr, .hostData
        );

        // clear-all must never come with a register write mode
        clearNoWrite: assert property (
                @(posedge clk) disable iff (!rstN)
                !(ctrl.clearRegs && (ctrl.rbMode != 3'd0))
        ) else $error("decoder set clearRegs with a write mode");

endmodule

/* src/hostPort.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module hostPort
        import corePkg::*;
(
        input  logic clk,
        input  logic rstN,
        input  logic [`AXI_AW-1:0] awaddr,
        input  logic awvalid,
        output logic awready,
        input  logic [`AXI_DW-1:0] wdata,
        input  logic wvalid,
        output logic wready,
        output logic [1:0] bresp,
        output logic bvalid,
        input  logic bready,
        input  logic [`AXI_AW-1:0] araddr,
        input  logic arvalid,
        output logic arready,
        output logic [`AXI_DW-1:0] rdata,
        output logic [1:0] rresp,
        output logic rvalid,
        input  logic rready,
        output logic execValid,
        output instrWord_u instr,
        input  logic haltReq,
        output logic [$clog2(`REG_N)-1:0] regAddr,
        input  logic [`DATA_W-1:0] regData
);

        logic running;
        logic wrAccept, wrFire, instrHit;
        logic arFire, regHit;
        logic [`AXI_AW-1:0] regOffset;

        // one-cycle ready pulse, held off while a response is outstanding
        assign wrAccept = awvalid && wvalid && !awready && !bvalid && !execValid;
        assign wrFire = awvalid && awready && wvalid && wready;
        assign instrHit = (awaddr == `ADDR_INSTR) && running;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        awready <= 1'b0;
                        wready <= 1'b0;
                        bvalid <= 1'b0;
                        bresp <= `RESP_OKAY;
                        execValid <= 1'b0;
                        instr <= '0;
                        running <= 1'b1;
                end else begin
                        awready <= wrAccept;
                        wready <= wrAccept;
                        execValid <= wrFire && instrHit;
                        if (wrFire && instrHit) begin
                                instr <= wdata[`DATA_W-1:0];
                        end
                        if (execValid && haltReq) begin
                                running <= 1'b0;
                        end
                        // okay follows the execute cycle, errors answer at once
                        if (wrFire && !instrHit) begin
                                bvalid <= 1'b1;
                                bresp <= `RESP_SLVERR;
                        end else if (execValid) begin
                                bvalid <= 1'b1;
                                bresp <= `RESP_OKAY;
                        end else if (bvalid && bready) begin
                                bvalid <= 1'b0;
                        end
                end
        end

        assign arready = !rvalid;
        assign arFire = arvalid && arready;

        assign regOffset = araddr - `ADDR_REG0;
        assign regHit = (araddr >= `ADDR_REG0) && (regOffset < 4 * `REG_N)
                        && (araddr[1:0] == 2'b00);
        assign regAddr = regOffset[$clog2(`REG_N)+1:2];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        rvalid <= 1'b0;
                end else if (arFire) begin
                        rvalid <= 1'b1;
                end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (arFire) begin
                        rdata <= '0;
                        rresp <= `RESP_OKAY;
                        if (regHit) begin
                                rdata[`DATA_W-1:0] <= regData;
                        end else if (araddr == `ADDR_STATUS) begin
                                rdata[0] <= running;
                        end else begin
                                rresp <= `RESP_SLVERR;
                        end
                end
        end

        bHold: assert property (
                @(posedge clk) disable iff (!rstN)
                bvalid && !bready |=> bvalid && $stable(bresp)
        ) else $error("write response dropped or changed before bready");

        rHold: assert property (
                @(posedge clk) disable iff (!rstN)
                rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
        ) else $error("read response dropped or changed before rready");

        execSingle: assert property (
                @(posedge clk) disable iff (!rstN)
                execValid |=> !execValid
        ) else $error("execValid held for two cycles");

endmodule

/* src/regBank.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module regBank (
        input  logic clk,
        input  logic rstN,
        input  logic we,
        input  logic clear,
        input  logic [$clog2(`REG_N)-1:0] wAddr,
        input  logic [`DATA_W-1:0] wData,
        input  logic [$clog2(`REG_N)-1:0] rsAddr,
        input  logic [$clog2(`REG_N)-1:0] rtAddr,
        output logic [`DATA_W-1:0] rsData,
        output logic [`DATA_W-1:0] rtData,
        input  logic [$clog2(`REG_N)-1:0] hostAddr,
        output logic [`DATA_W-1:0] hostData
);

        logic [`DATA_W-1:0] regs [`REG_N];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        for (int i = 0; i < `REG_N; i++) begin
                                regs[i] <= '0;
                        end
                end else if (clear) begin
                        // clear wins over a write in the same cycle
                        for (int i = 0; i < `REG_N; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we) begin
                        regs[wAddr] <= wData;
                end
        end

        assign rsData = regs[rsAddr];
        assign rtData = regs[rtAddr];
        assign hostData = regs[hostAddr];

        // decoder never asks for a write and a wipe together
        weClearExclusive: assert property (
                @(posedge clk) disable iff (!rstN)
                !(we && clear)
        ) else $error("register write and clear requested together");

endmodule

/* src/barrelShift.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module barrelShift
        import corePkg::*;
(
        input  shiftOp_e op,
        input  logic [`DATA_W-1:0] a,
        input  logic [`DATA_W-1:0] b,
        output logic [`DATA_W-1:0] y
);

        localparam int amtW = $clog2(`DATA_W);

        logic [amtW-1:0] amt;
        logic [2*`DATA_W-1:0] rotWide;

        assign amt = b[amtW-1:0];

        // rotate through a doubled copy, upper half holds the result
        assign rotWide = {a, a} << amt;

        always_comb begin
                case (op)
                        SH_SLL: y = a << amt;
                        SH_SRL: y = a >> amt;
                        SH_SRA: y = $signed(a) >>> amt;
                        SH_ROL: y = rotWide[2*`DATA_W-1:`DATA_W];
                        default: y = '0;
                endcase
        end

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module aluUnit
        import corePkg::*;
(
        input  aluOp_e op,
        input  logic [`DATA_W-1:0] a,
        input  logic [`DATA_W-1:0] b,
        output logic [`DATA_W-1:0] y
);

        // full width product, only the low half is kept
        logic [2*`DATA_W-1:0] prod;

        assign prod = a * b;

        always_comb begin
                y = '0;
                case (op)
                        ALU_AND: y = a & b;
                        ALU_ADD: y = a + b;
                        ALU_SUB: y = a - b;
                        ALU_OR: y = a | b;
                        ALU_XOR: y = a ^ b;
                        ALU_NOT: y = ~a;
                        ALU_NAND: y = ~(a & b);
                        ALU_NOR: y = ~(a | b);
                        ALU_XNOR: y = ~(a ^ b);
                        // signed compare, result is 1 or 0
                        ALU_SLT: y[0] = $signed(a) < $signed(b);
                        ALU_NEG: y = -b;
                        ALU_PASSB: y = b;
                        ALU_MUL: y = prod[`DATA_W-1:0];
                        ALU_PASSA: y = a;
                        default: y = '0;
                endcase
        end

endmodule

/* src/controlCore.sv */
`timescale 1ns/1ps

module controlCore
        import corePkg::*;
(
        input  logic [6:0] id,
        output ctrlBundle_t ctrl
);

        always_comb begin
                // plain register move unless the id says otherwise
                ctrl.aluOp = ALU_PASSB;
                ctrl.bsOp = SH_NONE;
                ctrl.useImm = 1'b0;
                ctrl.rbMode = 3'd1;
                ctrl.enable = 1'b1;
                ctrl.clearRegs = 1'b0;

                case (id)
                        7'd1: begin
                                ctrl.bsOp = SH_SRL;
                                ctrl.useImm = 1'b1;
                        end
                        7'd2: begin
                                ctrl.bsOp = SH_SRA;
                                ctrl.useImm = 1'b1;
                        end
                        7'd3: begin
                                ctrl.bsOp = SH_SLL;
                                ctrl.useImm = 1'b1;
                        end
                        7'd4, 7'd23: begin
                                ctrl.aluOp = ALU_ADD;
                        end
                        7'd5, 7'd22: begin
                                ctrl.aluOp = ALU_XOR;
                        end
                        7'd6, 7'd10: begin
                                ctrl.aluOp = ALU_ADD;
                                ctrl.useImm = 1'b1;
                        end
                        7'd7, 7'd9, 7'd11: begin
                                ctrl.aluOp = ALU_XOR;
                                ctrl.useImm = 1'b1;
                        end
                        // load immediate
                        7'd8: begin
                                ctrl.useImm = 1'b1;
                        end
                        7'd12: ctrl.aluOp = ALU_SUB;
                        7'd13: ctrl.aluOp = ALU_MUL;
                        7'd14: ctrl.bsOp = SH_SRL;
                        7'd15: ctrl.bsOp = SH_SRA;
                        7'd16: ctrl.bsOp = SH_SLL;
                        7'd17: ctrl.aluOp = ALU_AND;
                        7'd18: ctrl.aluOp = ALU_NOR;
                        7'd19: ctrl.bsOp = SH_ROL;
                        7'd20: ctrl.aluOp = ALU_PASSA;
                        7'd21: ctrl.aluOp = ALU_NOT;
                        7'd24: ctrl.aluOp = ALU_NAND;
                        7'd25: ctrl.aluOp = ALU_XNOR;
                        7'd26: ctrl.aluOp = ALU_OR;
                        7'd34: ctrl.aluOp = ALU_SLT;
                        7'd65: ctrl.aluOp = ALU_NEG;
                        7'd35, 7'd36, 7'd37: begin
                                // moves keep the defaults
                        end
                        // no-op
                        7'd74: ctrl.rbMode = 3'd0;
                        // halt
                        7'd75: begin
                                ctrl.rbMode = 3'd0;
                                ctrl.enable = 1'b0;
                        end
                        // wipe the whole register bank
                        7'd100: begin
                                ctrl.rbMode = 3'd0;
                                ctrl.clearRegs = 1'b1;
                        end
                        default: ctrl.rbMode = 3'd0;
                endcase
        end

endmodule

/* src/corePkg.sv */
package corePkg;

        // register form, three register fields
        typedef struct packed {
                logic [6:0] id;
                logic [2:0] rd;
                logic [2:0] rs;
                logic [2:0] rt;
        } rForm_t;

        // immediate form, destination plus signed 6-bit constant
        typedef struct packed {
                logic [6:0] id;
                logic [2:0] rd;
                logic signed [5:0] imm6;
        } iForm_t;

        typedef union packed {
                rForm_t rForm;
                iForm_t iForm;
        } instrWord_u;

        typedef enum logic [3:0] {
                ALU_ZERO = 4'd0,
                ALU_AND = 4'd1,
                ALU_ADD = 4'd2,
                ALU_SUB = 4'd3,
                ALU_OR = 4'd4,
                ALU_XOR = 4'd5,
                ALU_NOT = 4'd6,
                ALU_NAND = 4'd7,
                ALU_NOR = 4'd8,
                ALU_XNOR = 4'd9,
                ALU_SLT = 4'd10,
                ALU_NEG = 4'd11,
                ALU_PASSB = 4'd12,
                ALU_MUL = 4'd13,
                ALU_PASSA = 4'd14
        } aluOp_e;

        // codes 1 and 6..8 belong to memory ops, not kept here
        typedef enum logic [3:0] {
                SH_NONE = 4'd0,
                SH_SLL = 4'd2,
                SH_SRL = 4'd3,
                SH_SRA = 4'd4,
                SH_ROL = 4'd5
        } shiftOp_e;

        typedef struct packed {
                aluOp_e aluOp;
                shiftOp_e bsOp;
                logic useImm;
                logic [2:0] rbMode;
                logic enable;
                logic clearRegs;
        } ctrlBundle_t;

endpackage

/* src/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register bank
`define DATA_W 16
`define REG_N 8

// host bus widths
`define AXI_AW 8
`define AXI_DW 32

// register map
`define ADDR_INSTR 8'h00
`define ADDR_REG0 8'h40
`define ADDR_STATUS 8'h80

`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif
